// ==== source/spu_data_pkg.sv ====
package spu_data_pkg;

    // --------------------------------------------------
    // data path word
    // --------------------------------------------------
    localparam int DATA_BITS = 8;

    typedef logic [DATA_BITS-1:0] data_t;   // operand and result word

    // operation codes
    typedef enum logic [1:0] {
        op_nor = 2'd0,
        op_add = 2'd1
    } spu_op_e;

    // --------------------------------------------------
    // stream items
    // --------------------------------------------------

    // one input item
    typedef struct packed {
        data_t   data0;
        data_t   data1;
        spu_op_e op;
        logic    clear;   // force result to the clear value
        logic    valid;
    } spu_in_t;

    // one output item
    typedef struct packed {
        data_t data;
        logic  valid;
    } spu_out_t;

endpackage

// ==== source/spu_cfg_pkg.sv ====
package spu_cfg_pkg;

    import spu_data_pkg::*;

    // --------------------------------------------------
    // APB bus
    // --------------------------------------------------
    typedef logic [3:0]  apb_addr_t;   // byte address
    typedef logic [31:0] apb_data_t;   // bus word

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    // --------------------------------------------------
    // register map
    // --------------------------------------------------
    localparam apb_addr_t REG_CTRL  = 4'h0;   // bit 0 imm_en
    localparam apb_addr_t REG_IMM   = 4'h4;   // immediate operand in the low bits
    localparam apb_addr_t REG_COUNT = 4'h8;   // valid results that a write clears

    localparam int CTRL_IMM_EN_BIT = 0;

    // settings handed to the ALU
    typedef struct packed {
        logic  imm_en;   // replace operand 1
        data_t imm;
    } spu_cfg_t;

endpackage

// ==== source/spu_pipe_delay.sv ====
`timescale 1ns/10ps

module spu_pipe_delay #(
    parameter int               WIDTH       = 8,
    parameter int               STAGES      = 1,    // 0 gives a plain wire path
    parameter logic [WIDTH-1:0] RESET_VALUE = '0
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             cke,
    input  logic [WIDTH-1:0] in_data,
    output logic [WIDTH-1:0] out_data
);

    generate
        if (STAGES == 0) begin : g_bypass

            assign out_data = in_data;   // no stages requested

        end else begin : g_shift

            logic [WIDTH-1:0] stage_q [STAGES];   // stage 0 is the newest

            // whole line moves one step per enabled edge
            always_ff @(posedge clk) begin
                if (reset) begin
                    for (int i = 0; i < STAGES; i++) begin
                        stage_q[i] <= RESET_VALUE;
                    end
                end else if (cke) begin
                    stage_q[0] <= in_data;
                    for (int i = 1; i < STAGES; i++) begin
                        stage_q[i] <= stage_q[i-1];
                    end
                end
            end

            assign out_data = stage_q[STAGES-1];   // oldest stage

        end
    endgenerate

endmodule

// ==== source/spu_op_nor.sv ====
`timescale 1ns/10ps

module spu_op_nor
    import spu_data_pkg::*;
#(
    parameter data_t CLEAR_DATA = '1
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  cke,
    input  logic  clear,
    input  logic  valid,
    input  data_t data0,
    input  data_t data1,
    output data_t result
);

    // --------------------------------------------------
    // result register
    // --------------------------------------------------
    data_t result_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            result_q <= CLEAR_DATA;
        end else if (cke) begin
            if (clear) begin
                result_q <= CLEAR_DATA;        // clear wins over valid
            end else if (valid) begin
                result_q <= ~(data0 | data1);  // bitwise nor
            end
        end
    end

    // holds while no flag is set
    assign result = result_q;

endmodule

// ==== source/spu_op_add.sv ====
`timescale 1ns/10ps

module spu_op_add
    import spu_data_pkg::*;
#(
    parameter data_t CLEAR_DATA = '1
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  cke,
    input  logic  clear,
    input  logic  valid,
    input  data_t data0,
    input  data_t data1,
    output data_t result
);

    data_t sum;       // carry out dropped
    data_t result_q;

    // wraps modulo 2**DATA_BITS
    assign sum = data_t'(data0 + data1);

    // --------------------------------------------------
    // result register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            result_q <= CLEAR_DATA;
        end else if (cke) begin
            if (clear) begin
                result_q <= CLEAR_DATA;   // priority over valid
            end else if (valid) begin
                result_q <= sum;
            end
        end
    end

    assign result = result_q;   // hold on idle items

endmodule

// ==== source/spu_alu.sv ====
`timescale 1ns/10ps

module spu_alu
    import spu_data_pkg::*;
    import spu_cfg_pkg::*;
#(
    parameter int    LATENCY    = 2,
    parameter data_t CLEAR_DATA = '1
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     cke,
    input  spu_cfg_t cfg,
    input  spu_in_t  s_item,
    output spu_out_t m_item
);

    typedef struct packed {
        spu_op_e op;
        logic    live;   // valid or clear
    } ctrl_t;

    localparam int       TAIL_STAGES = (LATENCY >= 2) ? LATENCY - 2 : 0;
    localparam spu_out_t OUT_IDLE    = '{data: CLEAR_DATA, valid: 1'b0};

    spu_in_t  sub_item;   // operand 1 after imm substitution
    spu_in_t  op_item;    // what the operators see
    ctrl_t    ctrl_in;
    ctrl_t    ctrl_d;
    spu_op_e  last_op_q;  // op of the last live item
    spu_op_e  sel_op;
    data_t    nor_result;
    data_t    add_result;
    spu_out_t sel_out;

    always_comb begin
        sub_item = s_item;
        if (cfg.imm_en) begin
            sub_item.data1 = cfg.imm;
        end
    end

    // --------------------------------------------------
    // entry stage
    // --------------------------------------------------
    generate
        if (LATENCY >= 2) begin : g_entry
            always_ff @(posedge clk) begin
                if (reset) begin
                    op_item <= '0;
                end else if (cke) begin
                    op_item <= sub_item;   // cfg sampled here
                end
            end
        end else begin : g_direct
            assign op_item = sub_item;     // operators register directly
        end
    endgenerate

    spu_op_nor #(
        .CLEAR_DATA(CLEAR_DATA)
    ) nor_i (
        .clk   (clk),
        .reset (reset),
        .cke   (cke),
        .clear (op_item.clear & (op_item.op == op_nor)),
        .valid (op_item.valid & (op_item.op == op_nor)),
        .data0 (op_item.data0),
        .data1 (op_item.data1),
        .result(nor_result)
    );

    spu_op_add #(
        .CLEAR_DATA(CLEAR_DATA)
    ) add_i (
        .clk   (clk),
        .reset (reset),
        .cke   (cke),
        .clear (op_item.clear & (op_item.op == op_add)),
        .valid (op_item.valid & (op_item.op == op_add)),
        .data0 (op_item.data0),
        .data1 (op_item.data1),
        .result(add_result)
    );

    assign ctrl_in = '{op: op_item.op, live: op_item.valid | op_item.clear};

    // control travels alongside the operator stage
    spu_pipe_delay #(
        .WIDTH      ($bits(ctrl_t)),
        .STAGES     (1),
        .RESET_VALUE('0)
    ) ctrl_delay_i (
        .clk     (clk),
        .reset   (reset),
        .cke     (cke),
        .in_data (ctrl_in),
        .out_data(ctrl_d)
    );

    // --------------------------------------------------
    // result selection
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            last_op_q <= op_nor;
        end else if (cke && ctrl_d.live) begin
            last_op_q <= ctrl_d.op;
        end
    end

    // idle items keep pointing at the last live operator
    assign sel_op        = ctrl_d.live ? ctrl_d.op : last_op_q;
    assign sel_out.data  = (sel_op == op_add) ? add_result : nor_result;
    assign sel_out.valid = ctrl_d.live;

    spu_pipe_delay #(
        .WIDTH      ($bits(spu_out_t)),
        .STAGES     (TAIL_STAGES),
        .RESET_VALUE(OUT_IDLE)
    ) out_delay_i (
        .clk     (clk),
        .reset   (reset),
        .cke     (cke),
        .in_data (sel_out),
        .out_data(m_item)
    );

endmodule

// ==== source/spu_apb_regs.sv ====
`timescale 1ns/10ps

module spu_apb_regs
    import spu_cfg_pkg::*;
#(
    parameter int DATA_BITS = 8
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     cke,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    input  logic     result_valid,
    output spu_cfg_t cfg
);

    logic      access;     // access phase
    logic      wr_en;
    logic      rd_en;
    logic      hit_ctrl;
    logic      hit_imm;
    logic      hit_count;
    logic      mapped;
    spu_cfg_t  cfg_q;
    apb_data_t count_q;    // delivered results
    apb_data_t rdata;

    // --------------------------------------------------
    // decode
    // --------------------------------------------------
    assign access    = apb_req.psel & apb_req.penable;
    assign wr_en     = access & apb_req.pwrite;
    assign rd_en     = access & ~apb_req.pwrite;

    assign hit_ctrl  = (apb_req.paddr == REG_CTRL);
    assign hit_imm   = (apb_req.paddr == REG_IMM);
    assign hit_count = (apb_req.paddr == REG_COUNT);
    assign mapped    = hit_ctrl | hit_imm | hit_count;

    // --------------------------------------------------
    // registers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_q <= '0;
        end else if (wr_en) begin
            if (hit_ctrl) begin
                cfg_q.imm_en <= apb_req.pwdata[CTRL_IMM_EN_BIT];
            end
            if (hit_imm) begin
                cfg_q.imm <= apb_req.pwdata[DATA_BITS-1:0];   // upper bits ignored
            end
        end
    end

    // counter runs even during APB traffic
    always_ff @(posedge clk) begin
        if (reset) begin
            count_q <= '0;
        end else if (wr_en && hit_count) begin
            count_q <= '0;                // any write clears
        end else if (cke && result_valid) begin
            count_q <= count_q + 1'b1;
        end
    end

    // read mux
    always_comb begin
        rdata = '0;
        case (apb_req.paddr)
            REG_CTRL: begin
                rdata[CTRL_IMM_EN_BIT] = cfg_q.imm_en;
            end
            REG_IMM: begin
                rdata[DATA_BITS-1:0] = cfg_q.imm;
            end
            REG_COUNT: begin
                rdata = count_q;
            end
            default: begin
                rdata = '0;               // unmapped reads as zero
            end
        endcase
    end

    // --------------------------------------------------
    // response with zero wait states
    // --------------------------------------------------
    assign apb_rsp.prdata  = rd_en ? rdata : '0;
    assign apb_rsp.pready  = access;
    assign apb_rsp.pslverr = access & ~mapped;

    assign cfg = cfg_q;

endmodule

// ==== source/spu_top.sv ====
`timescale 1ns/10ps

module spu_top
    import spu_data_pkg::*;
    import spu_cfg_pkg::*;
#(
    parameter int    DATA_BITS  = spu_data_pkg::DATA_BITS,
    parameter int    LATENCY    = 2,    // at least 1
    parameter data_t CLEAR_DATA = '1
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     cke,
    input  spu_in_t  s_item,
    output spu_out_t m_item,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    spu_cfg_t cfg;           // register block to ALU
    spu_out_t out_item;

    // --------------------------------------------------
    // configuration registers
    // --------------------------------------------------
    spu_apb_regs #(
        .DATA_BITS(DATA_BITS)
    ) regs_i (
        .clk         (clk),
        .reset       (reset),
        .cke         (cke),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .result_valid(out_item.valid),   // counted per delivered result
        .cfg         (cfg)
    );

    // --------------------------------------------------
    // data path
    // --------------------------------------------------
    spu_alu #(
        .LATENCY   (LATENCY),
        .CLEAR_DATA(CLEAR_DATA)
    ) alu_i (
        .clk   (clk),
        .reset (reset),
        .cke   (cke),
        .cfg   (cfg),
        .s_item(s_item),
        .m_item(out_item)
    );

    assign m_item = out_item;

endmodule

// ==== dv/spu_tb.sv ====
`timescale 1ns/10ps

module spu_tb
    import spu_data_pkg::*;
    import spu_cfg_pkg::*;
;

    localparam data_t CLEAR_DATA  = '1;
    localparam int    DRAIN_LIMIT = 200;   // cycles
    localparam int    READY_LIMIT = 20;

    logic     clk = 1'b0;
    logic     reset;
    logic     cke;
    spu_in_t  s_item;
    spu_out_t m_item;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    spu_out_t    expect_q[$];            // results still to come out
    spu_out_t    expected;
    spu_out_t    hold_out;
    spu_cfg_t    shadow_cfg = '0;        // what the register block holds
    data_t       last_data  = CLEAR_DATA;
    logic [31:0] lfsr_state = 32'hf21b;
    int          valid_seen = 0;
    int          checks     = 0;
    int          errors     = 0;
    int          timeouts   = 0;
    string       phase      = "reset";

    spu_top #(
        .LATENCY   (2),
        .CLEAR_DATA(CLEAR_DATA)
    ) dut_i (
        .clk    (clk),
        .reset  (reset),
        .cke    (cke),
        .s_item (s_item),
        .m_item (m_item),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp)
    );

    always #50 clk = ~clk;

    // --------------------------------------------------
    // random numbers and reference model
    // --------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};   // one step per bit
        end
        return value;
    endfunction

    function automatic spu_out_t expected_out(input spu_in_t item, input spu_cfg_t cfg);
        data_t    b;
        spu_out_t res;
        b = cfg.imm_en ? cfg.imm : item.data1;
        res.valid = 1'b1;
        if (item.clear) begin
            res.data = CLEAR_DATA;            // clear beats valid
        end else if (item.op == op_add) begin
            res.data = item.data0 + b;        // wraps at 8 bits
        end else begin
            res.data = ~(item.data0 | b);
        end
        return res;
    endfunction

    function automatic data_t operand_of(input int kind);
        if (kind == 0) begin
            return '0;
        end else if (kind == 1) begin
            return '1;
        end
        return data_t'(rand_bits(DATA_BITS));
    endfunction

    // operand classes and flag pairs cycle with the index
    function automatic spu_in_t class_item(input int i);
        spu_in_t item;
        item.data0 = operand_of(i % 3);
        item.data1 = operand_of((i / 3) % 3);
        item.clear = (i % 4) >= 2;
        item.valid = (i % 2) == 1;
        item.op    = ((i / 36) % 2 == 1) ? op_add : op_nor;
        return item;
    endfunction

    function automatic spu_in_t random_item();
        spu_in_t item;
        item.data0 = data_t'(rand_bits(DATA_BITS));
        item.data1 = data_t'(rand_bits(DATA_BITS));
        item.op    = (rand_bits(1) == 1) ? op_add : op_nor;
        item.clear = (rand_bits(3) == 0);
        item.valid = (rand_bits(2) != 0);
        return item;
    endfunction

    // --------------------------------------------------
    // checks and end of run
    // --------------------------------------------------
    task automatic compare_out(input string name, input spu_out_t exp, input spu_out_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected data %h valid %b, actual data %h valid %b",
                     name, exp.data, exp.valid, act.data, act.valid);
        end
    endtask

    task automatic compare_apb(input string name, input apb_data_t exp, input apb_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    // --------------------------------------------------
    // stimulus tasks
    // --------------------------------------------------
    task automatic send_item(input spu_in_t item, input bit drops);
        if (drops && rand_bits(3) == 0) begin
            cke    = 1'b0;                    // one stalled cycle
            s_item = item;
            @(posedge clk);
            #5;
        end
        cke    = 1'b1;
        s_item = item;
        if (item.valid || item.clear) begin
            expect_q.push_back(expected_out(item, shadow_cfg));
        end
        @(posedge clk);
        #5;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        cke    = 1'b1;
        s_item = '0;                          // idle items only
        while (expect_q.size() != 0 && cycles < DRAIN_LIMIT) begin
            cycles++;
            @(posedge clk);
            #5;
        end
        if (expect_q.size() != 0) begin
            timeouts++;
            $display("timeout: %0d results never came out", expect_q.size());
            expect_q.delete();
        end
    endtask

    task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
        int cycles;
        cycles  = 0;
        cke     = 1'b1;
        s_item  = '0;
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clk);
        #5;
        apb_req.penable = 1'b1;               // access phase
        @(negedge clk);
        while (!apb_rsp.pready && cycles < READY_LIMIT) begin
            cycles++;
            @(negedge clk);
        end
        if (!apb_rsp.pready) begin
            timeouts++;
            $display("timeout: APB slave never raised pready at offset %h", addr);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        #5;
        apb_req = '0;
    endtask

    // --------------------------------------------------
    // comparator
    // --------------------------------------------------
    always @(posedge clk) begin
        if (!reset && cke) begin
            if (m_item.valid) begin
                valid_seen++;
                last_data = m_item.data;
                if (expect_q.size() == 0) begin
                    errors++;
                    $display("%s: output valid with no item pending", phase);
                end else begin
                    expected = expect_q.pop_front();
                    compare_out(phase, expected, m_item);
                end
            end else begin
                hold_out.data  = last_data;   // data must hold
                hold_out.valid = 1'b0;
                compare_out({phase, " hold"}, hold_out, m_item);
            end
        end
    end

    initial begin
        apb_data_t rdata;
        logic      err;
        reset   = 1'b1;
        cke     = 1'b0;
        s_item  = '0;
        apb_req = '0;
        repeat (8) @(posedge clk);
        #5;
        reset = 1'b0;
        cke   = 1'b1;
        hold_out.data  = CLEAR_DATA;
        hold_out.valid = 1'b0;
        compare_out("output after reset", hold_out, m_item);
        compare_flag("pready after reset", 1'b0, apb_rsp.pready);
        compare_flag("pslverr after reset", 1'b0, apb_rsp.pslverr);
        apb_access(1'b0, REG_COUNT, '0, rdata, err);
        compare_apb("count after reset", 32'h0, rdata);

        phase = "exhaustive";
        for (int i = 0; i < 256; i++) begin
            send_item(class_item(i), 1'b0);
        end
        wait_drain();

        phase = "random";
        for (int i = 0; i < 300; i++) begin
            send_item(random_item(), 1'b1);
        end
        wait_drain();

        phase = "immediate";
        apb_access(1'b1, REG_IMM, 32'h0000_a55a, rdata, err);
        compare_flag("imm write error", 1'b0, err);
        apb_access(1'b1, REG_CTRL, 32'h1, rdata, err);
        shadow_cfg.imm    = 8'h5a;            // upper bits dropped
        shadow_cfg.imm_en = 1'b1;
        apb_access(1'b0, REG_IMM, '0, rdata, err);
        compare_apb("imm readback", 32'h5a, rdata);
        for (int i = 0; i < 64; i++) begin
            send_item(random_item(), 1'b1);
        end
        wait_drain();
        phase = "imm off";
        apb_access(1'b1, REG_CTRL, 32'h0, rdata, err);
        shadow_cfg.imm_en = 1'b0;
        for (int i = 0; i < 64; i++) begin
            send_item(random_item(), 1'b1);
        end
        wait_drain();

        phase = "unmapped";
        apb_access(1'b1, 4'hc, 32'hffff_ffff, rdata, err);
        compare_flag("unmapped write error", 1'b1, err);
        apb_access(1'b0, 4'hc, '0, rdata, err);
        compare_flag("unmapped read error", 1'b1, err);
        compare_apb("unmapped read data", 32'h0, rdata);
        apb_access(1'b0, REG_CTRL, '0, rdata, err);
        compare_apb("ctrl after unmapped write", 32'h0, rdata);
        apb_access(1'b0, REG_IMM, '0, rdata, err);
        compare_apb("imm after unmapped write", 32'h5a, rdata);

        phase = "count";
        apb_access(1'b0, REG_COUNT, '0, rdata, err);
        compare_apb("count of results", apb_data_t'(valid_seen), rdata);
        apb_access(1'b1, REG_COUNT, 32'h1234, rdata, err);
        apb_access(1'b0, REG_COUNT, '0, rdata, err);
        compare_apb("count after clear", 32'h0, rdata);
        finish_run();
    end

endmodule

// ==== filelist.f ====
source/spu_data_pkg.sv
source/spu_cfg_pkg.sv
source/spu_pipe_delay.sv
source/spu_op_nor.sv
source/spu_op_add.sv
source/spu_alu.sv
source/spu_apb_regs.sv
source/spu_top.sv
dv/spu_tb.sv

// ==== Makefile ====
SRCS := $(wildcard source/*.sv) $(wildcard dv/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vspu_tb: $(SRCS) filelist.f
	verilator --binary --timing --timescale 1ns/10ps -j 0 \
		--top-module spu_tb -f filelist.f -o Vspu_tb

run: obj_dir/Vspu_tb
	./obj_dir/Vspu_tb | tee sim.log
	grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
